//--- include/telem_params.svh
// Build-time settings shared by all telemetry blocks; the lane count must not exceed four.
`ifndef TELEM_PARAMS_SVH
`define TELEM_PARAMS_SVH

// System clock in Hz.
// The testbench clock has a 100 ns period.
`define TELEM_CLK_FREQ_HZ 10_000_000

// Line rate of every lane in bits per second.
// Together with the clock this gives 10 clocks per bit.
`define TELEM_BAUD_RATE 1_000_000

// Number of independent UART lanes.
// It is bounded by the 2-bit lane field of a sample.
`define TELEM_NUM_LANES 4

`endif

//--- verilog/telem_pkg.sv
// Shared types; lane_idx_t is 2 bits wide, so at most four lanes can be addressed.
`default_nettype none

`include "telem_params.svh"

package telem_pkg;

    // Q16.16 fixed-point value, carried through without arithmetic.
    typedef logic [31:0] q16_16_t;

    // Lane number carried in each sample.
    typedef logic [1:0] lane_idx_t;

    // One bit per lane.
    typedef logic [`TELEM_NUM_LANES-1:0] lane_vec_t;

    // Incoming sample, 34 bits.
    typedef struct packed {
        lane_idx_t lane;
        q16_16_t   value;
    } sample_t;

    // Link status, 20 bits with four lanes.
    // The word counter wraps at 16 bits.
    typedef struct packed {
        lane_vec_t   busy;
        logic [15:0] word_count;
    } link_status_t;

endpackage

`default_nettype wire

//--- verilog/uart_byte_tx.sv
// 8N1 only; CLK_FREQ_HZ/BAUD_RATE must be at least 2, and tx_start is ignored while busy.
`timescale 1ns/10ps
`default_nettype none

`include "telem_params.svh"

module uart_byte_tx #(
    parameter int CLK_FREQ_HZ = `TELEM_CLK_FREQ_HZ,
    parameter int BAUD_RATE   = `TELEM_BAUD_RATE
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       tx_start,
    input  logic [7:0] tx_data,
    output logic       tx,
    output logic       tx_busy
);

    localparam int CLKS_PER_BIT = CLK_FREQ_HZ / BAUD_RATE;
    localparam int BAUD_W       = $clog2(CLKS_PER_BIT);
    localparam logic [BAUD_W-1:0] BAUD_LAST = BAUD_W'(CLKS_PER_BIT - 1);

    logic [BAUD_W-1:0] baud_cnt;
    logic [3:0]        bit_cnt;
    logic [8:0]        shift_reg;
    logic              load;
    logic              baud_tick;

    assign load      = tx_start && !tx_busy;
    assign baud_tick = (baud_cnt == BAUD_LAST);

    // Data bits LSB first, then the stop bit.
    // The start bit is driven onto the line directly at load.
    always_ff @(posedge clk) begin
        if (load) begin
            shift_reg <= {1'b1, tx_data};
        end else if (tx_busy && baud_tick) begin
            shift_reg <= {1'b1, shift_reg[8:1]};
        end
    end

    // Bit 0 is the start bit, bits 1 to 8 are data, bit 9 is the stop bit.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx       <= 1'b1;
            tx_busy  <= 1'b0;
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else if (load) begin
            tx       <= 1'b0;
            tx_busy  <= 1'b1;
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else if (tx_busy) begin
            if (baud_tick) begin
                baud_cnt <= '0;
                if (bit_cnt == 4'd9) begin
                    // Stop bit done, line is already high.
                    tx_busy <= 1'b0;
                end else begin
                    tx      <= shift_reg[0];
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end else begin
                baud_cnt <= baud_cnt + BAUD_W'(1);
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/uart_word_tx.sv
// Sends a 32-bit word as four 8N1 bytes LSB first; inter-byte gaps are a few clocks, not fixed.
`timescale 1ns/10ps
`default_nettype none

`include "telem_params.svh"

module uart_word_tx #(
    parameter int CLK_FREQ_HZ = `TELEM_CLK_FREQ_HZ,
    parameter int BAUD_RATE   = `TELEM_BAUD_RATE
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               word_valid,
    input  telem_pkg::q16_16_t word,
    output logic               word_ready,
    output logic               tx,
    output logic               busy,
    output logic               word_done
);

    import telem_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_LOAD,
        S_WAIT
    } state_t;

    state_t     state;
    q16_16_t    word_buf;
    logic [1:0] byte_idx;
    logic [7:0] tx_data;
    logic       tx_start;
    logic       tx_busy;
    logic       tx_busy_d;
    logic       tx_done;
    logic       last_byte;
    logic       accept;

    uart_byte_tx #(
        .CLK_FREQ_HZ(CLK_FREQ_HZ),
        .BAUD_RATE  (BAUD_RATE)
    ) i_byte_tx (
        .clk     (clk),
        .rst_n   (rst_n),
        .tx_start(tx_start),
        .tx_data (tx_data),
        .tx      (tx),
        .tx_busy (tx_busy)
    );

    assign word_ready = (state == S_IDLE);
    assign busy       = (state != S_IDLE);
    assign accept     = word_valid && word_ready;
    assign last_byte  = (byte_idx == 2'd3);

    // End of a byte is the falling edge of tx_busy.
    assign tx_done   = tx_busy_d && !tx_busy;
    assign word_done = (state == S_WAIT) && tx_done && last_byte;

    always_ff @(posedge clk) begin
        if (accept) begin
            word_buf <= word;
        end
        if (state == S_LOAD) begin
            tx_data <= word_buf[byte_idx*8 +: 8];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= S_IDLE;
            byte_idx  <= '0;
            tx_start  <= 1'b0;
            tx_busy_d <= 1'b0;
        end else begin
            tx_start  <= 1'b0;
            tx_busy_d <= tx_busy;
            case (state)
                S_IDLE: begin
                    if (accept) begin
                        byte_idx <= '0;
                        state    <= S_LOAD;
                    end
                end
                S_LOAD: begin
                    tx_start <= 1'b1;
                    state    <= S_WAIT;
                end
                S_WAIT: begin
                    if (tx_done) begin
                        if (last_byte) begin
                            state <= S_IDLE;
                        end else begin
                            byte_idx <= byte_idx + 2'd1;
                            state    <= S_LOAD;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/sample_router.sv
// One-entry buffer; a sample naming a lane at or above NUM_LANES is never released.
`timescale 1ns/10ps
`default_nettype none

`include "telem_params.svh"

module sample_router #(
    parameter int NUM_LANES = `TELEM_NUM_LANES
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 sample_valid,
    input  telem_pkg::sample_t   sample,
    output logic                 sample_ready,
    output logic [NUM_LANES-1:0] lane_valid,
    output telem_pkg::q16_16_t   lane_word,
    input  logic [NUM_LANES-1:0] lane_ready
);

    import telem_pkg::*;

    sample_t held;
    logic    held_valid;
    logic    take;
    logic    handoff;

    // Ready only while the holding register is empty.
    assign sample_ready = !held_valid;
    assign take         = sample_valid && sample_ready;

    // Only the addressed lane sees valid, so at most one bit is set here.
    assign handoff = |(lane_valid & lane_ready);

    assign lane_word = held.value;

    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            lane_valid[i] = held_valid && (held.lane == lane_idx_t'(i));
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            held <= sample;
        end
    end

    // A busy lane stalls the register, and with it every other lane.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            held_valid <= 1'b0;
        end else if (take) begin
            held_valid <= 1'b1;
        end else if (handoff) begin
            held_valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- verilog/link_status.sv
// Status lags the lanes by one clock; NUM_LANES must equal the width of the status busy vector.
`timescale 1ns/10ps
`default_nettype none

`include "telem_params.svh"

module link_status #(
    parameter int NUM_LANES = `TELEM_NUM_LANES
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [NUM_LANES-1:0]     busy,
    input  logic [NUM_LANES-1:0]     word_done,
    output telem_pkg::link_status_t  status
);

    import telem_pkg::*;

    localparam int SUM_W = $clog2(NUM_LANES + 1);

    logic [SUM_W-1:0] done_sum;

    if (NUM_LANES != $bits(lane_vec_t)) begin : g_lane_check
        $error("link_status: NUM_LANES does not match the status busy vector");
    end

    // Several lanes may finish a word in the same cycle.
    always_comb begin
        done_sum = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            done_sum = done_sum + SUM_W'(word_done[i]);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            status <= '0;
        end else begin
            status.busy       <= busy;
            status.word_count <= status.word_count + 16'(done_sum);
        end
    end

endmodule

`default_nettype wire

//--- verilog/telem_tx_top.sv
// All lanes share the clock and baud rate from telem_params.svh; one router entry feeds them all.
`timescale 1ns/10ps
`default_nettype none

`include "telem_params.svh"

module telem_tx_top #(
    parameter int NUM_LANES = `TELEM_NUM_LANES
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     sample_valid,
    input  telem_pkg::sample_t       sample,
    output logic                     sample_ready,
    output logic [NUM_LANES-1:0]     tx,
    output telem_pkg::link_status_t  status
);

    import telem_pkg::*;

    logic [NUM_LANES-1:0] lane_valid;
    logic [NUM_LANES-1:0] lane_ready;
    logic [NUM_LANES-1:0] lane_busy;
    logic [NUM_LANES-1:0] lane_done;
    q16_16_t              lane_word;

    sample_router #(
        .NUM_LANES(NUM_LANES)
    ) i_router (
        .clk         (clk),
        .rst_n       (rst_n),
        .sample_valid(sample_valid),
        .sample      (sample),
        .sample_ready(sample_ready),
        .lane_valid  (lane_valid),
        .lane_word   (lane_word),
        .lane_ready  (lane_ready)
    );

    // One word transmitter per lane, all fed from the shared lane_word.
    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        uart_word_tx #(
            .CLK_FREQ_HZ(`TELEM_CLK_FREQ_HZ),
            .BAUD_RATE  (`TELEM_BAUD_RATE)
        ) i_lane (
            .clk       (clk),
            .rst_n     (rst_n),
            .word_valid(lane_valid[i]),
            .word      (lane_word),
            .word_ready(lane_ready[i]),
            .tx        (tx[i]),
            .busy      (lane_busy[i]),
            .word_done (lane_done[i])
        );
    end

    link_status #(
        .NUM_LANES(NUM_LANES)
    ) i_status (
        .clk      (clk),
        .rst_n    (rst_n),
        .busy     (lane_busy),
        .word_done(lane_done),
        .status   (status)
    );

endmodule

`default_nettype wire

//--- tb/telem_tx_properties.sv
// Bound into telem_tx_top; all checks sample on the rising clock edge and use its internal lane nets.
`timescale 1ns/10ps
`default_nettype none

`include "telem_params.svh"

module telem_tx_properties #(
    parameter int NUM_LANES = `TELEM_NUM_LANES
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     sample_valid,
    input  logic                     sample_ready,
    input  logic [NUM_LANES-1:0]     tx,
    input  telem_pkg::link_status_t  status,
    input  logic [NUM_LANES-1:0]     lane_valid,
    input  logic [NUM_LANES-1:0]     lane_ready,
    input  logic [NUM_LANES-1:0]     lane_busy
);

    import telem_pkg::*;

    int fail_count = 0;

    // Outputs are idle on the first edge after reset is released.
    a_reset_idle: assert property (@(posedge clk)
        $rose(rst_n) |-> (&tx) && sample_ready && (status == '0))
        else begin
            fail_count++;
            $error("Outputs were not idle when reset was released");
        end

    // An offered word stays on its lane until that lane takes it.
    a_valid_held: assert property (@(posedge clk) disable iff (!rst_n)
        ((lane_valid != '0) && ((lane_valid & lane_ready) == '0)) |=> $stable(lane_valid))
        else begin
            fail_count++;
            $error("lane_valid changed before the lane accepted the word");
        end

    // A captured sample fills the single holding register.
    a_ready_drops: assert property (@(posedge clk) disable iff (!rst_n)
        (sample_valid && sample_ready) |=> !sample_ready)
        else begin
            fail_count++;
            $error("sample_ready stayed high after a sample was captured");
        end

    // A tx line only leaves idle while its lane holds an accepted word.
    a_no_spurious_start: assert property (@(posedge clk) disable iff (!rst_n)
        ((~tx & ~lane_busy) == '0))
        else begin
            fail_count++;
            $error("A tx line went low while its lane was idle");
        end

    // Status busy covers every frame.
    a_busy_in_frame: assert property (@(posedge clk) disable iff (!rst_n)
        ((~tx & ~status.busy) == '0))
        else begin
            fail_count++;
            $error("A status busy bit was low while its tx line was inside a frame");
        end

endmodule

`default_nettype wire

//--- tb/telem_tx_tb.sv
// Runs with the defaults of telem_params.svh; all traffic comes from a fixed LCG seed.
`timescale 1ns/10ps
`default_nettype none

`include "telem_params.svh"

module telem_tx_tb;

    import telem_pkg::*;

    localparam int NUM_LANES    = `TELEM_NUM_LANES;
    localparam int CLKS_PER_BIT = `TELEM_CLK_FREQ_HZ / `TELEM_BAUD_RATE;
    localparam int FRAME_CLKS   = 10 * CLKS_PER_BIT;
    localparam int WORD_TIMEOUT = 8 * FRAME_CLKS;
    localparam int NUM_RANDOM   = 24;

    logic                 clk;
    logic                 rst_n;
    logic                 sample_valid;
    sample_t              sample;
    logic                 sample_ready;
    logic [NUM_LANES-1:0] tx;
    link_status_t         status;

    q16_16_t     exp_q [NUM_LANES][$];
    int          rx_words [NUM_LANES];
    bit          in_frame [NUM_LANES];
    int          errors;
    int          max_overlap;
    bit          rx_stop;
    logic [31:0] seed;

    telem_tx_top i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .sample_valid(sample_valid),
        .sample      (sample),
        .sample_ready(sample_ready),
        .tx          (tx),
        .status      (status)
    );

    bind telem_tx_top telem_tx_properties i_props (
        .clk         (clk),
        .rst_n       (rst_n),
        .sample_valid(sample_valid),
        .sample_ready(sample_ready),
        .tx          (tx),
        .status      (status),
        .lane_valid  (lane_valid),
        .lane_ready  (lane_ready),
        .lane_busy   (lane_busy)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Called on a falling edge; returns on the falling edge after the capture.
    task automatic send_sample(input lane_idx_t lane, input q16_16_t value, output int stall);
        stall = 0;
        sample_valid = 1'b1;
        sample.lane  = lane;
        sample.value = value;
        while (!sample_ready && stall < WORD_TIMEOUT) begin
            @(negedge clk);
            stall++;
        end
        if (!sample_ready) begin
            $display("Timeout: sample for lane %0d was never accepted", lane);
            errors++;
        end else begin
            exp_q[lane].push_back(value);
        end
        @(negedge clk);
        sample_valid = 1'b0;
    endtask

    // UART receiver for one lane, sampling each bit near its middle.
    task automatic rx_lane(input int lane);
        q16_16_t got;
        q16_16_t exp;
        int      waited;
        while (!rx_stop) begin
            @(negedge clk);
            if (tx[lane] === 1'b0) begin
                got = '0;
                for (int b = 0; b < 4; b++) begin
                    if (b > 0) begin
                        waited = 0;
                        while (tx[lane] !== 1'b0 && waited < 4 * CLKS_PER_BIT) begin
                            @(negedge clk);
                            waited++;
                        end
                        if (tx[lane] !== 1'b0) begin
                            $display("Lane %0d: byte %0d of a word never started", lane, b);
                            errors++;
                        end
                    end
                    in_frame[lane] = 1'b1;
                    repeat (CLKS_PER_BIT / 2) @(negedge clk);
                    assert (tx[lane] === 1'b0) else begin
                        $display("MISMATCH %0t tx[%0d] start bit: got %b expected 0",
                                 $time, lane, tx[lane]);
                        errors++;
                    end
                    for (int k = 0; k < 8; k++) begin
                        repeat (CLKS_PER_BIT) @(negedge clk);
                        got[b*8 + k] = tx[lane];
                    end
                    repeat (CLKS_PER_BIT) @(negedge clk);
                    assert (tx[lane] === 1'b1) else begin
                        $display("MISMATCH %0t tx[%0d] stop bit: got %b expected 1",
                                 $time, lane, tx[lane]);
                        errors++;
                    end
                    in_frame[lane] = 1'b0;
                end
                rx_words[lane]++;
                if (exp_q[lane].size() == 0) begin
                    $display("Lane %0d received word %08h that was never sent", lane, got);
                    errors++;
                end else begin
                    exp = exp_q[lane].pop_front();
                    assert (got == exp) else begin
                        $display("MISMATCH %0t tx[%0d] word: got %08h expected %08h",
                                 $time, lane, got, exp);
                        errors++;
                    end
                end
            end
        end
    endtask

    task automatic track_overlap();
        int active;
        while (!rx_stop) begin
            @(posedge clk);
            active = 0;
            for (int i = 0; i < NUM_LANES; i++) begin
                if (in_frame[i]) begin
                    active++;
                end
            end
            if (active > max_overlap) begin
                max_overlap = active;
            end
        end
    endtask

    task automatic wait_lanes_idle();
        int waited;
        bit pending;
        waited  = 0;
        pending = 1'b1;
        while (pending && waited < 4 * WORD_TIMEOUT) begin
            @(negedge clk);
            waited++;
            pending = (status.busy != '0);
            for (int i = 0; i < NUM_LANES; i++) begin
                if (exp_q[i].size() != 0) begin
                    pending = 1'b1;
                end
            end
        end
        if (pending) begin
            $display("Timeout: lanes still busy or words still missing");
            errors++;
        end
    endtask

    initial begin
        int          stall;
        int          total;
        lane_idx_t   lane;
        rst_n        = 1'b0;
        sample_valid = 1'b0;
        sample       = '0;
        errors       = 0;
        max_overlap  = 0;
        rx_stop      = 1'b0;
        seed         = 32'h3bc6;
        for (int i = 0; i < NUM_LANES; i++) begin
            rx_words[i] = 0;
            in_frame[i] = 1'b0;
        end
        for (int i = 0; i < NUM_LANES; i++) begin
            fork
                automatic int l = i;
                rx_lane(l);
            join_none
        end
        fork
            track_overlap();
        join_none
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        // One word per lane in quick succession.
        for (int i = 0; i < NUM_LANES; i++) begin
            seed = lcg_next(seed);
            send_sample(lane_idx_t'(i), seed, stall);
        end
        wait_lanes_idle();
        assert (max_overlap >= 2) else begin
            $display("Frames on different lanes never overlapped in time");
            errors++;
        end

        // Two words for one lane, then one for another lane behind them.
        seed = lcg_next(seed);
        lane = seed[9:8];
        send_sample(lane, seed, stall);
        seed = lcg_next(seed);
        send_sample(lane, seed, stall);
        seed = lcg_next(seed);
        send_sample(lane + 2'd1, seed, stall);
        assert (stall >= 3 * FRAME_CLKS) else begin
            $display("sample_ready returned after %0d cycles while the lane was still busy",
                     stall);
            errors++;
        end
        wait_lanes_idle();

        // Random lanes and values.
        for (int n = 0; n < NUM_RANDOM; n++) begin
            seed = lcg_next(seed);
            lane = seed[17:16];
            seed = lcg_next(seed);
            send_sample(lane, seed, stall);
        end
        wait_lanes_idle();

        // Quiet stretch with no samples offered.
        for (int n = 0; n < 2 * FRAME_CLKS; n++) begin
            @(negedge clk);
            assert (&tx) else begin
                $display("A tx line left idle with no sample offered");
                errors++;
            end
        end

        total = 0;
        for (int i = 0; i < NUM_LANES; i++) begin
            total += rx_words[i];
        end
        assert (status.word_count == 16'(total)) else begin
            $display("MISMATCH %0t status.word_count: got %0d expected %0d",
                     $time, status.word_count, total);
            errors++;
        end

        rx_stop = 1'b1;
        $display("Checks finished: %0d words, %0d testbench errors, %0d assertion failures",
                 total, errors, i_dut.i_props.fail_count);
        if (errors == 0 && i_dut.i_props.fail_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+include
verilog/telem_pkg.sv
verilog/uart_byte_tx.sv
verilog/uart_word_tx.sv
verilog/sample_router.sv
verilog/link_status.sv
verilog/telem_tx_top.sv
tb/telem_tx_properties.sv
tb/telem_tx_tb.sv

//--- Makefile
TOP := telem_tx_tb
LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) --Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
